/* fma_unit.f */
logic/fma_pkg.sv
logic/fma_lzc.sv
logic/fma_decode.sv
logic/fma_execute.sv
logic/fma_result.sv
logic/fma_unit.sv
sim/fma_unit_tb.sv

/* logic/fma_decode.sv */
// FMA decode, operation adjustment, operand classification and special-case results
`timescale 1ns/1ps
`default_nettype none

module fma_decode (
  input  fma_pkg::fp_word_t operand_a_i,
  input  fma_pkg::fp_word_t operand_b_i,
  input  fma_pkg::fp_word_t operand_c_i,
  input  fma_pkg::op_e      op_i,
  input  logic              op_mod_i,      // Inverts the addend sign
  output logic              sign_a_o, sign_b_o, sign_c_o,
  output fma_pkg::exp_t     exp_a_o, exp_b_o, exp_c_o,
  output fma_pkg::mant_t    mant_a_o, mant_b_o, mant_c_o,
  output logic              prod_zero_o,
  output logic              eff_sub_o,     // Product and addend signs differ
  output logic              special_o,
  output fma_pkg::fp_word_t special_word_o,
  output fma_pkg::status_t  special_status_o
);

  fma_pkg::fp_word_t word [3];              // Adjusted A, B, C
  logic [2:0]        exp_min, exp_max, man_zero;
  logic [2:0]        is_zero, is_inf, is_nan, is_snan;
  logic              prod_inf;              // Either multiplicand infinite

  // Internal exponent, zero and subnormal fields both read as 1
  function automatic fma_pkg::exp_t int_exp(input fma_pkg::fp_word_t w);
    logic [fma_pkg::EXP_BITS-1:0] field;
    field = w[fma_pkg::MAN_BITS+:fma_pkg::EXP_BITS];
    return (field == '0) ? fma_pkg::exp_t'(1) : fma_pkg::exp_t'(field);
  endfunction

  // ---------------------------------------------------------------------
  // Operation table
  // ---------------------------------------------------------------------
  always_comb begin : op_adjust
    word[0] = operand_a_i;
    word[1] = operand_b_i;
    word[2] = operand_c_i ^ {op_mod_i, {(fma_pkg::EXP_BITS + fma_pkg::MAN_BITS){1'b0}}};
    case (op_i)
      fma_pkg::FMADD:  ;                                   // As given
      fma_pkg::FNMSUB: word[0][15] = ~operand_a_i[15];    // Negated product
      fma_pkg::ADD:    word[0] = fma_pkg::fp_word_t'(fma_pkg::BIAS << fma_pkg::MAN_BITS); // +1.0
      fma_pkg::MUL:    word[2] = {1'b1, {(fma_pkg::EXP_BITS + fma_pkg::MAN_BITS){1'b0}}}; // -0
      default:         ;
    endcase
  end

  // Zero, subnormal, normal, inf, qNaN, sNaN from the field extremes
  always_comb begin : classify
    for (int i = 0; i < 3; i++) begin
      exp_min[i]  = ~|word[i][fma_pkg::MAN_BITS+:fma_pkg::EXP_BITS];
      exp_max[i]  = &word[i][fma_pkg::MAN_BITS+:fma_pkg::EXP_BITS];
      man_zero[i] = ~|word[i][fma_pkg::MAN_BITS-1:0];
      is_snan[i]  = exp_max[i] & ~man_zero[i] & ~word[i][fma_pkg::MAN_BITS-1]; // Quiet bit clear
    end
  end

  assign is_zero  = exp_min & man_zero;
  assign is_inf   = exp_max & man_zero;
  assign is_nan   = exp_max & ~man_zero;
  assign prod_inf = is_inf[0] | is_inf[1];

  assign sign_a_o = word[0][15];
  assign sign_b_o = word[1][15];
  assign sign_c_o = word[2][15];
  assign exp_a_o  = int_exp(word[0]);
  assign exp_b_o  = int_exp(word[1]);
  assign exp_c_o  = int_exp(word[2]);
  assign mant_a_o = {~exp_min[0], word[0][fma_pkg::MAN_BITS-1:0]};  // Hidden bit for normals
  assign mant_b_o = {~exp_min[1], word[1][fma_pkg::MAN_BITS-1:0]};
  assign mant_c_o = {~exp_min[2], word[2][fma_pkg::MAN_BITS-1:0]};

  assign prod_zero_o = is_zero[0] | is_zero[1];
  assign eff_sub_o   = sign_a_o ^ sign_b_o ^ sign_c_o;

  // ---------------------------------------------------------------------
  // Special cases, highest priority first
  // ---------------------------------------------------------------------
  always_comb begin : special_cases
    special_o        = 1'b1;
    special_word_o   = fma_pkg::QNAN_WORD;
    special_status_o = '0;
    if ((is_inf[0] & is_zero[1]) | (is_zero[0] & is_inf[1])) begin
      special_status_o[fma_pkg::STATUS_NV] = 1'b1;  // inf x 0, whatever the addend
    end else if (|is_nan) begin
      special_status_o[fma_pkg::STATUS_NV] = |is_snan;
    end else if (prod_inf & is_inf[2] & eff_sub_o) begin
      special_status_o[fma_pkg::STATUS_NV] = 1'b1;  // inf - inf
    end else if (prod_inf) begin
      special_word_o = {sign_a_o ^ sign_b_o, {fma_pkg::EXP_BITS{1'b1}}, {fma_pkg::MAN_BITS{1'b0}}};
    end else if (is_inf[2]) begin
      special_word_o = {sign_c_o, {fma_pkg::EXP_BITS{1'b1}}, {fma_pkg::MAN_BITS{1'b0}}};
    end else begin
      special_o = 1'b0;  // Regular datapath
    end
  end

endmodule

`default_nettype wire

/* logic/fma_execute.sv */
// FMA execute stage, exponent path, product, addend alignment, adder and normalization
`timescale 1ns/1ps
`default_nettype none

module fma_execute (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          valid_i,
  input  fma_pkg::round_e               rnd_mode_i,
  input  logic                          sign_a_i, sign_b_i, sign_c_i,
  input  fma_pkg::exp_t                 exp_a_i, exp_b_i, exp_c_i,
  input  fma_pkg::mant_t                mant_a_i, mant_b_i, mant_c_i,
  input  logic                          prod_zero_i,
  input  logic                          eff_sub_i,
  input  logic                          special_i,
  input  fma_pkg::fp_word_t             special_word_i,
  input  fma_pkg::status_t              special_status_i,
  output logic                          valid_o,
  output fma_pkg::round_e               rnd_mode_o,
  output logic                          sign_o,
  output fma_pkg::exp_t                 exp_o,
  output logic [fma_pkg::PREC_BITS:0]   mant_o,     // Hidden bit, fraction, round bit
  output logic                          sticky_o,
  output logic                          eff_sub_o,
  output logic                          special_o,
  output fma_pkg::fp_word_t             special_word_o,
  output fma_pkg::status_t              special_status_o
);

  fma_pkg::exp_t                                    exp_prod, exp_diff, lzc_exp;
  fma_pkg::shamt_t                                  addend_shamt, norm_shamt;
  logic [2*fma_pkg::PREC_BITS-1:0]                  product;
  fma_pkg::sum_t                                    prod_shifted, addend_aligned, addend_term;
  logic [fma_pkg::SUM_WIDTH+fma_pkg::PREC_BITS-2:0] addend_wide;  // Aligned addend plus spill
  logic                                             sticky_add;
  logic [fma_pkg::SUM_WIDTH:0]                      sum_raw, sum_shifted;  // Carry on top
  fma_pkg::sum_t                                    sum;
  logic                                             prod_sign, final_sign;
  logic [fma_pkg::LZC_CNT_BITS-1:0]                 lz_count;
  logic                                             lz_empty;
  fma_pkg::exp_t                                    norm_exp, exp_d;
  logic [fma_pkg::PREC_BITS:0]                      mant_d;
  logic [fma_pkg::LZC_WIDTH-1:0]                    sticky_bits;

  // ---------------------------------------------------------------------
  // Exponents and addend shift
  // ---------------------------------------------------------------------
  assign exp_prod = prod_zero_i ? fma_pkg::exp_t'(2 - fma_pkg::BIAS)  // Smallest, keeps c exact
                                : exp_a_i + exp_b_i - fma_pkg::exp_t'(fma_pkg::BIAS);
  assign exp_diff = exp_c_i - exp_prod;

  always_comb begin : addend_shift
    if (exp_diff <= fma_pkg::exp_t'(-2 * fma_pkg::PREC_BITS))
      addend_shamt = fma_pkg::shamt_t'(3 * fma_pkg::PREC_BITS + 3);   // Addend only sticky
    else if (exp_diff <= fma_pkg::exp_t'(fma_pkg::PREC_BITS + 2))
      addend_shamt = fma_pkg::shamt_t'(fma_pkg::PREC_BITS + 3 - exp_diff);
    else
      addend_shamt = '0;  // Product only sticky
  end

  // Product sits at | 0 (p+2) | a*b (2p) | R S |
  assign product      = mant_a_i * mant_b_i;
  assign prod_shifted = fma_pkg::sum_t'({product, 2'b00});

  // Addend starts left of the whole sum, bits shifted below it fold into sticky
  assign addend_wide    = {mant_c_i, {(fma_pkg::SUM_WIDTH - 1){1'b0}}} >> addend_shamt;
  assign sticky_add     = |addend_wide[fma_pkg::PREC_BITS-1:0];
  assign addend_aligned = {addend_wide[fma_pkg::SUM_WIDTH+fma_pkg::PREC_BITS-2:fma_pkg::PREC_BITS],
                           sticky_add};
  assign addend_term    = eff_sub_i ? ~addend_aligned : addend_aligned;

  // ---------------------------------------------------------------------
  // Adder with sign fix
  // ---------------------------------------------------------------------
  assign sum_raw   = prod_shifted + addend_term + eff_sub_i;
  assign sum       = (eff_sub_i && !sum_raw[fma_pkg::SUM_WIDTH]) ? fma_pkg::sum_t'(-sum_raw)
                                                                 : sum_raw[fma_pkg::SUM_WIDTH-1:0];
  assign prod_sign = sign_a_i ^ sign_b_i;
  // No carry on a subtraction means the addend was larger
  assign final_sign = (eff_sub_i && !sum_raw[fma_pkg::SUM_WIDTH]) ? sign_c_i : prod_sign;

  fma_lzc u_lzc (
    .bits_i  (sum[fma_pkg::LZC_WIDTH-1:0]),
    .count_o (lz_count),
    .empty_o (lz_empty)
  );

  // ---------------------------------------------------------------------
  // Normalization
  // ---------------------------------------------------------------------
  assign lzc_exp = exp_prod - fma_pkg::exp_t'({2'b00, lz_count}) + 7'sd1;

  always_comb begin : norm_shift
    if ((exp_diff <= 0) || (eff_sub_i && (exp_diff <= 2))) begin
      // Product-anchored or cancellation, LZC decides
      if (!lz_empty && (lzc_exp >= 0)) begin
        norm_shamt = fma_pkg::shamt_t'(fma_pkg::PREC_BITS + 2 + lz_count);
        norm_exp   = lzc_exp;
      end else begin
        norm_shamt = fma_pkg::shamt_t'(fma_pkg::PREC_BITS + 2 + exp_prod);  // Subnormal cap
        norm_exp   = '0;
      end
    end else begin
      norm_shamt = addend_shamt;  // Undo the alignment
      norm_exp   = exp_c_i;
    end
  end

  assign sum_shifted = {1'b0, sum} << norm_shamt;

  // Leading one may sit one bit either side of the MSB
  always_comb begin : small_norm
    {mant_d, sticky_bits} = sum_shifted[fma_pkg::SUM_WIDTH-1:0];
    exp_d                 = norm_exp;
    if (sum_shifted[fma_pkg::SUM_WIDTH]) begin
      {mant_d, sticky_bits} = sum_shifted[fma_pkg::SUM_WIDTH:1];
      exp_d                 = norm_exp + 7'sd1;
    end else if (!sum_shifted[fma_pkg::SUM_WIDTH-1]) begin
      if (norm_exp > 1) begin
        {mant_d, sticky_bits} = {sum_shifted[fma_pkg::SUM_WIDTH-2:0], 1'b0};
        exp_d                 = norm_exp - 7'sd1;
      end else begin
        exp_d = '0;  // Stays subnormal
      end
    end
  end

  // Stage register
  always_ff @(posedge clk_i) begin
    if (!rst_n_i)
      valid_o <= 1'b0;
    else
      valid_o <= valid_i;
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      rnd_mode_o       <= rnd_mode_i;
      sign_o           <= final_sign;
      exp_o            <= exp_d;
      mant_o           <= mant_d;
      sticky_o         <= (|sticky_bits) | sticky_add;
      eff_sub_o        <= eff_sub_i;
      special_o        <= special_i;
      special_word_o   <= special_word_i;
      special_status_o <= special_status_i;
    end
  end

endmodule

`default_nettype wire

/* logic/fma_lzc.sv */
// Leading-zero counter with an all-zero flag, searched from the MSB down
`timescale 1ns/1ps
`default_nettype none

module fma_lzc (
  input  logic [fma_pkg::LZC_WIDTH-1:0]    bits_i,
  output logic [fma_pkg::LZC_CNT_BITS-1:0] count_o,
  output logic                             empty_o   // No bit set
);

  always_comb begin : search
    count_o = '0;
    empty_o = 1'b1;
    // Count every zero seen before the first one
    for (int i = fma_pkg::LZC_WIDTH - 1; i >= 0; i--) begin
      if (bits_i[i])
        empty_o = 1'b0;
      else if (empty_o)
        count_o = count_o + 1'b1;  // Still above the leading one
    end
  end

endmodule

`default_nettype wire

/* logic/fma_pkg.sv */
// Half-precision FMA package with format constants, datapath types and encodings
`default_nettype none

package fma_pkg;

  // ---------------------------------------------------------------------
  // binary16 format
  // ---------------------------------------------------------------------
  localparam int EXP_BITS  = 5;             // Exponent field
  localparam int MAN_BITS  = 10;            // Stored fraction
  localparam int BIAS      = 15;
  localparam int PREC_BITS = MAN_BITS + 1;  // p, hidden bit included

  // Datapath widths
  localparam int SUM_WIDTH    = 3 * PREC_BITS + 4;  // Adder incl. round and sticky
  localparam int LZC_WIDTH    = 2 * PREC_BITS + 3;  // Lower sum bits searched for the leading one
  localparam int LZC_CNT_BITS = $clog2(LZC_WIDTH);
  localparam int EXP_WIDTH    = EXP_BITS + 2;       // Signed, holds every intermediate exponent
  localparam int SHAMT_BITS   = $clog2(SUM_WIDTH);

  typedef logic [EXP_BITS+MAN_BITS:0]  fp_word_t;  // Sign, exponent, fraction
  typedef logic [PREC_BITS-1:0]        mant_t;     // Hidden bit plus fraction
  typedef logic signed [EXP_WIDTH-1:0] exp_t;
  typedef logic [SHAMT_BITS-1:0]       shamt_t;
  typedef logic [SUM_WIDTH-1:0]        sum_t;
  typedef logic [4:0]                  status_t;

  localparam fp_word_t QNAN_WORD = 16'h7E00;  // Canonical quiet NaN

  // Flag positions, RISC-V fflags order
  localparam int STATUS_NV = 4;  // Invalid
  localparam int STATUS_DZ = 3;  // Divide by zero
  localparam int STATUS_OF = 2;
  localparam int STATUS_UF = 1;
  localparam int STATUS_NX = 0;  // Inexact

  typedef enum logic [1:0] {
    FMADD,
    FNMSUB,
    ADD,
    MUL
  } op_e;

  typedef enum logic [2:0] {
    RNE = 3'd0,  // Nearest, ties to even
    RTZ = 3'd1,
    RDN = 3'd2,  // Toward -inf
    RUP = 3'd3,  // Toward +inf
    RMM = 3'd4   // Nearest, ties away from zero
  } round_e;

endpackage

`default_nettype wire

/* logic/fma_result.sv */
// FMA result stage, rounding, flags, special-case select and output register
`timescale 1ns/1ps
`default_nettype none

module fma_result (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        valid_i,
  input  fma_pkg::round_e             rnd_mode_i,
  input  logic                        sign_i,
  input  fma_pkg::exp_t               exp_i,
  input  logic [fma_pkg::PREC_BITS:0] mant_i,
  input  logic                        sticky_i,
  input  logic                        eff_sub_i,
  input  logic                        special_i,
  input  fma_pkg::fp_word_t           special_word_i,
  input  fma_pkg::status_t            special_status_i,
  output fma_pkg::fp_word_t           result_o,
  output fma_pkg::status_t            status_o,
  output logic                        out_valid_o
);

  logic [fma_pkg::EXP_BITS+fma_pkg::MAN_BITS-1:0] pre_abs, rounded_abs;  // Magnitude only
  logic                                           of_before, of_after, uf_after;
  logic                                           round_bit, sticky_bit, round_up;
  logic                                           exact_zero, res_sign;
  fma_pkg::status_t                               regular_status;

  // ---------------------------------------------------------------------
  // Rounding
  // ---------------------------------------------------------------------
  assign of_before = exp_i >= fma_pkg::exp_t'((1 << fma_pkg::EXP_BITS) - 1);

  // On overflow start from the largest normal and force rounding bits
  assign pre_abs = of_before ? {{(fma_pkg::EXP_BITS - 1){1'b1}}, 1'b0, {fma_pkg::MAN_BITS{1'b1}}}
                             : {exp_i[fma_pkg::EXP_BITS-1:0], mant_i[fma_pkg::MAN_BITS:1]};
  assign round_bit  = mant_i[0] | of_before;
  assign sticky_bit = sticky_i | of_before;

  always_comb begin : round_decision
    case (rnd_mode_i)
      fma_pkg::RNE: round_up = round_bit & (sticky_bit | pre_abs[0]);
      fma_pkg::RTZ: round_up = 1'b0;
      fma_pkg::RDN: round_up = sign_i & (round_bit | sticky_bit);
      fma_pkg::RUP: round_up = ~sign_i & (round_bit | sticky_bit);
      fma_pkg::RMM: round_up = round_bit;
      default:      round_up = 1'b0;
    endcase
  end

  assign rounded_abs = pre_abs + round_up;  // Carry walks into the exponent
  assign exact_zero  = (pre_abs == '0) & ~round_bit & ~sticky_bit;
  // x - x gives +0, except -0 when rounding down
  assign res_sign    = (exact_zero && eff_sub_i) ? (rnd_mode_i == fma_pkg::RDN) : sign_i;

  assign of_after = &rounded_abs[fma_pkg::MAN_BITS+:fma_pkg::EXP_BITS];
  assign uf_after = ~|rounded_abs[fma_pkg::MAN_BITS+:fma_pkg::EXP_BITS] & ~exact_zero;

  always_comb begin : flags
    regular_status                     = '0;
    regular_status[fma_pkg::STATUS_NV] = 1'b0;  // Invalid cases take the special path
    regular_status[fma_pkg::STATUS_DZ] = 1'b0;  // No division here
    regular_status[fma_pkg::STATUS_OF] = of_before | of_after;
    regular_status[fma_pkg::STATUS_UF] = uf_after;
    regular_status[fma_pkg::STATUS_NX] = round_bit | sticky_bit | of_before | of_after;
  end

  // ---------------------------------------------------------------------
  // Output register
  // ---------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i)
      out_valid_o <= 1'b0;
    else
      out_valid_o <= valid_i;
  end

  // Holds the last result between strobes
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      result_o <= special_i ? special_word_i : {res_sign, rounded_abs};
      status_o <= special_i ? special_status_i : regular_status;
    end
  end

endmodule

`default_nettype wire

/* logic/fma_unit.sv */
// Half-precision FMA top level, decode then execute and result stages, two-cycle latency
`timescale 1ns/1ps
`default_nettype none

module fma_unit (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              in_valid_i,
  input  fma_pkg::fp_word_t operand_a_i,
  input  fma_pkg::fp_word_t operand_b_i,
  input  fma_pkg::fp_word_t operand_c_i,
  input  fma_pkg::op_e      op_i,
  input  logic              op_mod_i,
  input  fma_pkg::round_e   rnd_mode_i,
  output fma_pkg::fp_word_t result_o,
  output fma_pkg::status_t  status_o,
  output logic              out_valid_o
);

  // Decode to execute
  logic                        dec_sign_a, dec_sign_b, dec_sign_c;
  fma_pkg::exp_t               dec_exp_a, dec_exp_b, dec_exp_c;
  fma_pkg::mant_t              dec_mant_a, dec_mant_b, dec_mant_c;
  logic                        dec_prod_zero, dec_eff_sub, dec_special;
  fma_pkg::fp_word_t           dec_special_word;
  fma_pkg::status_t            dec_special_status;

  // Execute to result, registered
  logic                        ex_valid, ex_sign, ex_sticky, ex_eff_sub, ex_special;
  fma_pkg::round_e             ex_rnd_mode;
  fma_pkg::exp_t               ex_exp;
  logic [fma_pkg::PREC_BITS:0] ex_mant;
  fma_pkg::fp_word_t           ex_special_word;
  fma_pkg::status_t            ex_special_status;

  fma_decode u_decode (
    .operand_a_i      (operand_a_i),
    .operand_b_i      (operand_b_i),
    .operand_c_i      (operand_c_i),
    .op_i             (op_i),
    .op_mod_i         (op_mod_i),
    .sign_a_o         (dec_sign_a),
    .sign_b_o         (dec_sign_b),
    .sign_c_o         (dec_sign_c),
    .exp_a_o          (dec_exp_a),
    .exp_b_o          (dec_exp_b),
    .exp_c_o          (dec_exp_c),
    .mant_a_o         (dec_mant_a),
    .mant_b_o         (dec_mant_b),
    .mant_c_o         (dec_mant_c),
    .prod_zero_o      (dec_prod_zero),
    .eff_sub_o        (dec_eff_sub),
    .special_o        (dec_special),
    .special_word_o   (dec_special_word),
    .special_status_o (dec_special_status)
  );

  fma_execute u_execute (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .valid_i          (in_valid_i),
    .rnd_mode_i       (rnd_mode_i),
    .sign_a_i         (dec_sign_a),
    .sign_b_i         (dec_sign_b),
    .sign_c_i         (dec_sign_c),
    .exp_a_i          (dec_exp_a),
    .exp_b_i          (dec_exp_b),
    .exp_c_i          (dec_exp_c),
    .mant_a_i         (dec_mant_a),
    .mant_b_i         (dec_mant_b),
    .mant_c_i         (dec_mant_c),
    .prod_zero_i      (dec_prod_zero),
    .eff_sub_i        (dec_eff_sub),
    .special_i        (dec_special),
    .special_word_i   (dec_special_word),
    .special_status_i (dec_special_status),
    .valid_o          (ex_valid),
    .rnd_mode_o       (ex_rnd_mode),
    .sign_o           (ex_sign),
    .exp_o            (ex_exp),
    .mant_o           (ex_mant),
    .sticky_o         (ex_sticky),
    .eff_sub_o        (ex_eff_sub),
    .special_o        (ex_special),
    .special_word_o   (ex_special_word),
    .special_status_o (ex_special_status)
  );

  fma_result u_result (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .valid_i          (ex_valid),
    .rnd_mode_i       (ex_rnd_mode),
    .sign_i           (ex_sign),
    .exp_i            (ex_exp),
    .mant_i           (ex_mant),
    .sticky_i         (ex_sticky),
    .eff_sub_i        (ex_eff_sub),
    .special_i        (ex_special),
    .special_word_i   (ex_special_word),
    .special_status_i (ex_special_status),
    .result_o         (result_o),
    .status_o         (status_o),
    .out_valid_o      (out_valid_o)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build with Verilator and run the FMA testbench, pass only on the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module fma_unit_tb -f fma_unit.f \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/Vfma_unit_tb 2>&1 | tee /dev/stderr | grep -q "Simulation PASSED" \
  && echo "Run passed" \
  || { echo "Run failed"; exit 1; }

/* sim/fma_unit_tb.sv */
// Testbench for the half-precision FMA unit that issues a table of operations back to back
`timescale 1ns/1ps
`default_nettype none

module fma_unit_tb;

  localparam int LATENCY     = 2;  // Falling edges from issue to result
  localparam int DRAIN_LIMIT = 8;  // Cycles allowed for the last results

  logic              clk_i;
  logic              rst_n_i;
  logic              in_valid_i;
  fma_pkg::fp_word_t operand_a_i, operand_b_i, operand_c_i;
  fma_pkg::op_e      op_i;
  logic              op_mod_i;
  fma_pkg::round_e   rnd_mode_i;
  fma_pkg::fp_word_t result_o;
  fma_pkg::status_t  status_o;
  logic              out_valid_o;

  // Stimulus and expected values with one entry per row
  string             name_tab[$];
  fma_pkg::fp_word_t a_tab[$], b_tab[$], c_tab[$];
  fma_pkg::op_e      op_tab[$];
  logic              mod_tab[$];
  fma_pkg::round_e   rnd_tab[$];
  fma_pkg::fp_word_t res_tab[$];
  fma_pkg::status_t  stat_tab[$];

  int row_q[$];    // Rows in flight
  int issue_q[$];  // Issue cycle of each row in flight
  int cycle;

  fma_unit uut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .operand_c_i (operand_c_i),
    .op_i        (op_i),
    .op_mod_i    (op_mod_i),
    .rnd_mode_i  (rnd_mode_i),
    .result_o    (result_o),
    .status_o    (status_o),
    .out_valid_o (out_valid_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;  // 100 ns period
  end

  // ---------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------
  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected 0x%h, actual 0x%h", name, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic fail_run(input string what);
    $display("Run stopped: %s", what);
    $display("Simulation FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic add_row(input string name, input fma_pkg::fp_word_t a, input fma_pkg::fp_word_t b,
                         input fma_pkg::fp_word_t c, input fma_pkg::op_e op, input logic op_mod,
                         input fma_pkg::round_e rnd, input fma_pkg::fp_word_t res,
                         input fma_pkg::status_t stat);
    name_tab.push_back(name);
    a_tab.push_back(a);
    b_tab.push_back(b);
    c_tab.push_back(c);
    op_tab.push_back(op);
    mod_tab.push_back(op_mod);
    rnd_tab.push_back(rnd);
    res_tab.push_back(res);
    stat_tab.push_back(stat);
  endtask

  task automatic drive_row(input int row);
    in_valid_i  = 1'b1;
    operand_a_i = a_tab[row];
    operand_b_i = b_tab[row];
    operand_c_i = c_tab[row];
    op_i        = op_tab[row];
    op_mod_i    = mod_tab[row];
    rnd_mode_i  = rnd_tab[row];
  endtask

  // Sampled on the falling edge when outputs have settled since the rising edge
  task automatic collect_result();
    int row;
    int issued;
    if (out_valid_o) begin
      if (row_q.size() == 0) begin
        fail_run("out_valid_o went high with no operation in flight");
      end else begin
        row    = row_q.pop_front();
        issued = issue_q.pop_front();
        check_value({name_tab[row], " latency"}, 16'(LATENCY), 16'(cycle - issued));
        check_value({name_tab[row], " result"}, res_tab[row], result_o);
        check_value({name_tab[row], " status"}, 16'(stat_tab[row]), 16'(status_o));
      end
    end else if (issue_q.size() != 0 && (cycle - issue_q[0]) >= LATENCY) begin
      fail_run("out_valid_o stayed low when a result was due");
    end
  endtask

  // ---------------------------------------------------------------------
  // Table with status bits in the order NV DZ OF UF NX
  // ---------------------------------------------------------------------
  task automatic build_table();
    add_row("fmadd_exact", 16'h3E00, 16'h4000, 16'h3400, fma_pkg::FMADD, 1'b0, fma_pkg::RNE,
            16'h4280, 5'h00);  // 1.5*2+0.25
    add_row("fmsub_exact", 16'h3E00, 16'h4000, 16'h3400, fma_pkg::FMADD, 1'b1, fma_pkg::RNE,
            16'h4180, 5'h00);  // 2.75
    add_row("fnmsub_exact", 16'h3E00, 16'h4000, 16'h3400, fma_pkg::FNMSUB, 1'b0, fma_pkg::RNE,
            16'hC180, 5'h00);  // -3+0.25
    add_row("cancel_rne", 16'h3E00, 16'h4000, 16'h4200, fma_pkg::FMADD, 1'b1, fma_pkg::RNE,
            16'h0000, 5'h00);
    add_row("cancel_rdn", 16'h3E00, 16'h4000, 16'h4200, fma_pkg::FMADD, 1'b1, fma_pkg::RDN,
            16'h8000, 5'h00);  // -0 when rounding down
    add_row("add_sub", 16'h0000, 16'h4500, 16'h4000, fma_pkg::ADD, 1'b1, fma_pkg::RNE,
            16'h4200, 5'h00);  // 5-2 with A unused
    add_row("mul_ignores_c", 16'h3E00, 16'h4100, 16'h4000, fma_pkg::MUL, 1'b0, fma_pkg::RNE,
            16'h4380, 5'h00);  // 1.5*2.5
    add_row("mul_subnormal", 16'h0401, 16'h3800, 16'h3C00, fma_pkg::MUL, 1'b0, fma_pkg::RNE,
            16'h0200, 5'h03);  // Tie on the subnormal grid stays even
    // 1 + 2^-11 + 2^-20 lies just above half an ulp
    add_row("round_rne", 16'h1002, 16'h3C00, 16'h3C00, fma_pkg::FMADD, 1'b0, fma_pkg::RNE,
            16'h3C01, 5'h01);
    add_row("round_rtz", 16'h1002, 16'h3C00, 16'h3C00, fma_pkg::FMADD, 1'b0, fma_pkg::RTZ,
            16'h3C00, 5'h01);
    add_row("round_rup", 16'h1002, 16'h3C00, 16'h3C00, fma_pkg::FMADD, 1'b0, fma_pkg::RUP,
            16'h3C01, 5'h01);
    add_row("round_rdn", 16'h1002, 16'h3C00, 16'h3C00, fma_pkg::FMADD, 1'b0, fma_pkg::RDN,
            16'h3C00, 5'h01);
    add_row("round_rmm", 16'h1002, 16'h3C00, 16'h3C00, fma_pkg::FMADD, 1'b0, fma_pkg::RMM,
            16'h3C01, 5'h01);
    // Same sum negated
    add_row("round_neg_rdn", 16'h1002, 16'h3C00, 16'h3C00, fma_pkg::FNMSUB, 1'b1, fma_pkg::RDN,
            16'hBC01, 5'h01);
    add_row("round_neg_rup", 16'h1002, 16'h3C00, 16'h3C00, fma_pkg::FNMSUB, 1'b1, fma_pkg::RUP,
            16'hBC00, 5'h01);
    add_row("overflow_rne", 16'h7BFF, 16'h4000, 16'h0000, fma_pkg::MUL, 1'b0, fma_pkg::RNE,
            16'h7C00, 5'h05);  // 65504*2
    add_row("overflow_rtz", 16'h7BFF, 16'h4000, 16'h0000, fma_pkg::MUL, 1'b0, fma_pkg::RTZ,
            16'h7BFF, 5'h05);  // Largest normal
    add_row("inf_times_zero", 16'h7C00, 16'h0000, 16'h3C00, fma_pkg::FMADD, 1'b0, fma_pkg::RNE,
            16'h7E00, 5'h10);
    add_row("snan_input", 16'h7D00, 16'h3C00, 16'h3C00, fma_pkg::FMADD, 1'b0, fma_pkg::RNE,
            16'h7E00, 5'h10);
    add_row("qnan_input", 16'h3C00, 16'h7E00, 16'h3C00, fma_pkg::FMADD, 1'b0, fma_pkg::RNE,
            16'h7E00, 5'h00);  // Quiet NaN raises no NV
    add_row("inf_minus_inf", 16'h7C00, 16'h3C00, 16'hFC00, fma_pkg::FMADD, 1'b0, fma_pkg::RNE,
            16'h7E00, 5'h10);
    add_row("inf_product", 16'h7C00, 16'h4000, 16'h3C00, fma_pkg::FMADD, 1'b0, fma_pkg::RNE,
            16'h7C00, 5'h00);
  endtask

  // ---------------------------------------------------------------------
  // Main sequence
  // ---------------------------------------------------------------------
  initial begin : run
    int drain;
    build_table();
    rst_n_i     = 1'b0;
    in_valid_i  = 1'b1;  // Strobe high so only the reset keeps the pipe empty
    operand_a_i = '0;
    operand_b_i = '0;
    operand_c_i = '0;
    op_i        = fma_pkg::FMADD;
    op_mod_i    = 1'b0;
    rnd_mode_i  = fma_pkg::RNE;
    cycle       = 0;
    repeat (2) @(posedge clk_i);  // Two reset cycles
    @(negedge clk_i);
    rst_n_i    = 1'b1;
    in_valid_i = 1'b0;
    check_value("reset out_valid", 16'd0, 16'(out_valid_o));

    // One row per cycle without gaps
    for (int i = 0; i < name_tab.size(); i++) begin
      @(negedge clk_i);
      cycle++;
      collect_result();
      drive_row(i);
      row_q.push_back(i);
      issue_q.push_back(cycle);
    end

    drain = 0;
    while (row_q.size() != 0 && drain < DRAIN_LIMIT) begin
      @(negedge clk_i);
      cycle++;
      in_valid_i = 1'b0;
      collect_result();
      drain++;
    end

    if (row_q.size() != 0) begin
      fail_run("timeout waiting for out_valid_o on the last results");
    end else begin
      @(negedge clk_i);
      cycle++;
      collect_result();  // Strobe drops once the pipe is empty
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire
